// ==== periph_settings.svh ====
/*
 * Widths, address map and register offsets of the peripheral subsystem.
 * Included by the package and by every block that decodes addresses or offsets.
 */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

`define PERIPH_ADDR_W        32
`define PERIPH_DATA_W        32
`define PERIPH_GPIO_W        16
`define PERIPH_CORE_INTR_W   8
`define PERIPH_IRQ_SRC_N     16

`define PERIPH_GPIO_BASE     32'h2000_0000
`define PERIPH_IRQ_BASE      32'h2000_1000
`define PERIPH_WIN_SIZE      32'h0000_0100

// GPIO register offsets
`define GPIO_DIR_OFS         8'h00
`define GPIO_OUT_OFS         8'h04
`define GPIO_IN_OFS          8'h08
`define GPIO_INTR_EN_OFS     8'h0C
`define GPIO_INTR_STAT_OFS   8'h10

// Interrupt controller register offsets
`define IRQ_ENABLE_OFS       8'h00
`define IRQ_PENDING_OFS      8'h04
`define IRQ_CLAIM_OFS        8'h08

`endif

// ==== periph_pkg.sv ====
/*
 * Shared types of the peripheral subsystem: bus fields, pin and
 * interrupt vectors, and the access target selected by the address decoder.
 */
`include "periph_settings.svh"

package periph_pkg;

  typedef logic [`PERIPH_ADDR_W-1:0] addr_t;
  typedef logic [`PERIPH_DATA_W-1:0] data_t;
  typedef logic [`PERIPH_DATA_W/8-1:0] be_t;

  // Byte offset inside one peripheral window
  typedef logic [$clog2(`PERIPH_WIN_SIZE)-1:0] reg_ofs_t;

  // One bit per GPIO pin
  typedef logic [`PERIPH_GPIO_W-1:0] gpio_t;

  // One bit per interrupt source, ID 0 never fires
  typedef logic [`PERIPH_IRQ_SRC_N-1:0] irq_src_t;
  typedef logic [$clog2(`PERIPH_IRQ_SRC_N)-1:0] irq_id_t;

  typedef enum logic [1:0] {
    TARGET_NONE,
    TARGET_GPIO,
    TARGET_IRQ
  } target_e;

endpackage

// ==== periph_req_decode.sv ====
/*
 * Request stage: grants master requests, decodes the address against the
 * two peripheral windows and holds the access for one cycle.
 */
`include "periph_settings.svh"

module periph_req_decode (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  periph_pkg::addr_t     addr_i,
  input  logic                  we_i,
  input  periph_pkg::be_t       be_i,
  input  periph_pkg::data_t     wdata_i,
  output logic                  gnt_o,
  output logic                  acc_valid_o,
  output periph_pkg::target_e   acc_target_o,
  output logic                  gpio_acc_o,
  output logic                  irq_acc_o,
  output logic                  acc_we_o,
  output periph_pkg::reg_ofs_t  acc_ofs_o,
  output periph_pkg::data_t     acc_wdata_o,
  output periph_pkg::be_t       acc_be_o
);

  logic                 accept;
  periph_pkg::addr_t    gpio_rel;
  periph_pkg::addr_t    irq_rel;
  periph_pkg::target_e  dec_target;

  logic                 acc_valid_q;
  periph_pkg::target_e  acc_target_q;

  // No back-pressure, every request is taken once out of reset
  assign gnt_o  = req_i & ~reset_i;
  assign accept = req_i & gnt_o;

  // Window match by offset from each base
  assign gpio_rel = addr_i - periph_pkg::addr_t'(`PERIPH_GPIO_BASE);
  assign irq_rel  = addr_i - periph_pkg::addr_t'(`PERIPH_IRQ_BASE);

  always_comb begin
    if (gpio_rel < periph_pkg::addr_t'(`PERIPH_WIN_SIZE)) begin
      dec_target = periph_pkg::TARGET_GPIO;
    end else if (irq_rel < periph_pkg::addr_t'(`PERIPH_WIN_SIZE)) begin
      dec_target = periph_pkg::TARGET_IRQ;
    end else begin
      dec_target = periph_pkg::TARGET_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_valid_q  <= 1'b0;
      acc_target_q <= periph_pkg::TARGET_NONE;
    end else begin
      acc_valid_q  <= accept;
      acc_target_q <= dec_target;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      acc_we_o    <= we_i;
      acc_ofs_o   <= periph_pkg::reg_ofs_t'(addr_i);
      acc_wdata_o <= wdata_i;
      acc_be_o    <= be_i;
    end
  end

  assign acc_valid_o  = acc_valid_q;
  assign acc_target_o = acc_target_q;
  assign gpio_acc_o   = acc_valid_q && (acc_target_q == periph_pkg::TARGET_GPIO);
  assign irq_acc_o    = acc_valid_q && (acc_target_q == periph_pkg::TARGET_IRQ);

  // Only one register block sees an access at a time
  a_one_target: assert property (@(posedge clk_i) disable iff (reset_i)
    !(gpio_acc_o && irq_acc_o));

endmodule

// ==== gpio_bank.sv ====
/*
 * GPIO bank: direction and output registers, synchronized inputs and
 * rising-edge interrupt status with a per-pin enable.
 */
`include "periph_settings.svh"

module gpio_bank (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  acc_i,
  input  logic                  we_i,
  input  periph_pkg::reg_ofs_t  ofs_i,
  input  periph_pkg::data_t     wdata_i,
  input  periph_pkg::be_t       be_i,
  input  periph_pkg::gpio_t     gpio_i,
  output periph_pkg::data_t     rdata_o,
  output periph_pkg::gpio_t     gpio_o,
  output periph_pkg::gpio_t     gpio_oe_o,
  output periph_pkg::gpio_t     gpio_intr_o
);

  logic               wr;
  periph_pkg::gpio_t  lane_mask;
  periph_pkg::gpio_t  wdata_pins;
  periph_pkg::gpio_t  rise;
  periph_pkg::gpio_t  stat_clr;

  periph_pkg::gpio_t  dir_q;
  periph_pkg::gpio_t  out_q;
  periph_pkg::gpio_t  intr_en_q;
  periph_pkg::gpio_t  intr_stat_q;
  periph_pkg::gpio_t  sync1_q;
  periph_pkg::gpio_t  sync2_q;
  periph_pkg::gpio_t  prev_q;

  assign wr         = acc_i & we_i;
  assign lane_mask  = {{8{be_i[1]}}, {8{be_i[0]}}};
  assign wdata_pins = periph_pkg::gpio_t'(wdata_i);

  // Edge seen on the synchronized value
  assign rise = sync2_q & ~prev_q;

  assign stat_clr = (wr && ofs_i == `GPIO_INTR_STAT_OFS) ? (wdata_pins & lane_mask) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dir_q       <= '0;
      out_q       <= '0;
      intr_en_q   <= '0;
      intr_stat_q <= '0;
      sync1_q     <= '0;
      sync2_q     <= '0;
      prev_q      <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr && ofs_i == `GPIO_DIR_OFS) begin
        dir_q <= (dir_q & ~lane_mask) | (wdata_pins & lane_mask);
      end
      if (wr && ofs_i == `GPIO_OUT_OFS) begin
        out_q <= (out_q & ~lane_mask) | (wdata_pins & lane_mask);
      end
      if (wr && ofs_i == `GPIO_INTR_EN_OFS) begin
        intr_en_q <= (intr_en_q & ~lane_mask) | (wdata_pins & lane_mask);
      end
      // A new edge wins over a clear in the same cycle
      intr_stat_q <= (intr_stat_q & ~stat_clr) | rise;
    end
  end

  always_comb begin
    case (ofs_i)
      `GPIO_DIR_OFS:       rdata_o = periph_pkg::data_t'(dir_q);
      `GPIO_OUT_OFS:       rdata_o = periph_pkg::data_t'(out_q);
      `GPIO_IN_OFS:        rdata_o = periph_pkg::data_t'(sync2_q);
      `GPIO_INTR_EN_OFS:   rdata_o = periph_pkg::data_t'(intr_en_q);
      `GPIO_INTR_STAT_OFS: rdata_o = periph_pkg::data_t'(intr_stat_q);
      default:             rdata_o = '0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_oe_o   = dir_q;
  assign gpio_intr_o = intr_stat_q & intr_en_q;

endmodule

// ==== irq_ctrl.sv ====
/*
 * Reduced interrupt controller with enable, pending and claim/complete.
 * Sources are level sensitive, a CLAIM read returns the lowest pending ID.
 */
`include "periph_settings.svh"

module irq_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  acc_i,
  input  logic                  we_i,
  input  periph_pkg::reg_ofs_t  ofs_i,
  input  periph_pkg::data_t     wdata_i,
  input  periph_pkg::be_t       be_i,
  input  periph_pkg::irq_src_t  src_i,
  output periph_pkg::data_t     rdata_o,
  output logic                  irq_o
);

  logic                  wr;
  periph_pkg::irq_src_t  lane_mask;
  periph_pkg::irq_src_t  enable_d;
  periph_pkg::irq_src_t  cmpl_mask;
  periph_pkg::irq_id_t   cmpl_id;
  periph_pkg::irq_id_t   claim_id;

  periph_pkg::irq_src_t  enable_q;
  periph_pkg::irq_src_t  pending_q;

  assign wr        = acc_i & we_i;
  assign lane_mask = {{8{be_i[1]}}, {8{be_i[0]}}};

  always_comb begin
    enable_d = (enable_q & ~lane_mask) | (periph_pkg::irq_src_t'(wdata_i) & lane_mask);
    // ID 0 means no interrupt and can never be enabled
    enable_d[0] = 1'b0;
  end

  // Completion names the ID in the low byte
  assign cmpl_id   = periph_pkg::irq_id_t'(wdata_i);
  assign cmpl_mask = (wr && be_i[0] && ofs_i == `IRQ_CLAIM_OFS) ?
                     (periph_pkg::irq_src_t'(1) << cmpl_id) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q  <= '0;
      pending_q <= '0;
    end else begin
      if (wr && ofs_i == `IRQ_ENABLE_OFS) begin
        enable_q <= enable_d;
      end
      // A source still asserted keeps its pending bit through completion
      pending_q <= (pending_q & ~cmpl_mask) | (src_i & enable_q);
    end
  end

  // Lowest pending ID has priority
  always_comb begin
    claim_id = '0;
    for (int i = `PERIPH_IRQ_SRC_N - 1; i > 0; i--) begin
      if (pending_q[i]) begin
        claim_id = periph_pkg::irq_id_t'(i);
      end
    end
  end

  always_comb begin
    case (ofs_i)
      `IRQ_ENABLE_OFS:  rdata_o = periph_pkg::data_t'(enable_q);
      `IRQ_PENDING_OFS: rdata_o = periph_pkg::data_t'(pending_q);
      `IRQ_CLAIM_OFS:   rdata_o = periph_pkg::data_t'(claim_id);
      default:          rdata_o = '0;
    endcase
  end

  assign irq_o = |pending_q;

  // Whenever the core is interrupted there is something to claim
  a_irq_has_id: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_o |-> claim_id != '0);

endmodule

// ==== periph_resp.sv ====
/*
 * Response stage: picks the read data of the accessed block, flags a
 * decode error and returns one rvalid pulse per access.
 */
module periph_resp (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 acc_valid_i,
  input  periph_pkg::target_e  acc_target_i,
  input  periph_pkg::data_t    gpio_rdata_i,
  input  periph_pkg::data_t    irq_rdata_i,
  output logic                 rvalid_o,
  output periph_pkg::data_t    rdata_o,
  output logic                 err_o
);

  periph_pkg::data_t  rdata_sel;

  always_comb begin
    case (acc_target_i)
      periph_pkg::TARGET_GPIO: rdata_sel = gpio_rdata_i;
      periph_pkg::TARGET_IRQ:  rdata_sel = irq_rdata_i;
      default:                 rdata_sel = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= acc_valid_i;
      err_o    <= acc_valid_i && (acc_target_i == periph_pkg::TARGET_NONE);
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_valid_i) begin
      rdata_o <= rdata_sel;
    end
  end

  a_rvalid_after_access: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o |-> $past(acc_valid_i));

endmodule

// ==== periph_subsystem.sv ====
/*
 * Peripheral subsystem top: bus request, GPIO bank, interrupt controller
 * and response stage, plus routing of the interrupt lines.
 */
`include "periph_settings.svh"

module periph_subsystem (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           req_i,
  input  periph_pkg::addr_t              addr_i,
  input  logic                           we_i,
  input  periph_pkg::be_t                be_i,
  input  periph_pkg::data_t              wdata_i,
  input  periph_pkg::gpio_t              gpio_i,
  input  logic [1:0]                     ext_intr_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output periph_pkg::data_t              rdata_o,
  output logic                           err_o,
  output periph_pkg::gpio_t              gpio_o,
  output periph_pkg::gpio_t              gpio_oe_o,
  output logic [`PERIPH_CORE_INTR_W-1:0] gpio_intr_o,
  output logic                           irq_o
);

  logic                  acc_valid;
  periph_pkg::target_e   acc_target;
  logic                  gpio_acc;
  logic                  irq_acc;
  logic                  acc_we;
  periph_pkg::reg_ofs_t  acc_ofs;
  periph_pkg::data_t     acc_wdata;
  periph_pkg::be_t       acc_be;
  periph_pkg::data_t     gpio_rdata;
  periph_pkg::data_t     irq_rdata;
  periph_pkg::gpio_t     gpio_intr;
  periph_pkg::irq_src_t  irq_src;

  periph_req_decode periph_req_decode_i (
    .clk_i, .reset_i, .req_i, .addr_i, .we_i, .be_i, .wdata_i, .gnt_o,
    .acc_valid_o(acc_valid), .acc_target_o(acc_target),
    .gpio_acc_o(gpio_acc), .irq_acc_o(irq_acc), .acc_we_o(acc_we),
    .acc_ofs_o(acc_ofs), .acc_wdata_o(acc_wdata), .acc_be_o(acc_be)
  );

  gpio_bank gpio_bank_i (
    .clk_i, .reset_i, .acc_i(gpio_acc), .we_i(acc_we), .ofs_i(acc_ofs),
    .wdata_i(acc_wdata), .be_i(acc_be), .gpio_i, .rdata_o(gpio_rdata),
    .gpio_o, .gpio_oe_o, .gpio_intr_o(gpio_intr)
  );

  // Low pins go straight to the core, the rest through the controller
  assign gpio_intr_o = gpio_intr[`PERIPH_CORE_INTR_W-1:0];
  // ID 0 reserved, IDs 1-8 pins 8-15, IDs 9-10 external lines, IDs 11-15 unused
  assign irq_src = {5'b0, ext_intr_i, gpio_intr[`PERIPH_GPIO_W-1:`PERIPH_CORE_INTR_W], 1'b0};

  irq_ctrl irq_ctrl_i (
    .clk_i, .reset_i, .acc_i(irq_acc), .we_i(acc_we), .ofs_i(acc_ofs),
    .wdata_i(acc_wdata), .be_i(acc_be), .src_i(irq_src),
    .rdata_o(irq_rdata), .irq_o
  );

  periph_resp periph_resp_i (
    .clk_i, .reset_i, .acc_valid_i(acc_valid), .acc_target_i(acc_target),
    .gpio_rdata_i(gpio_rdata), .irq_rdata_i(irq_rdata),
    .rvalid_o, .rdata_o, .err_o
  );

endmodule

// ==== tb_periph_subsystem.sv ====
/*
 * Testbench for the peripheral subsystem. Drives bus accesses, GPIO pins and
 * external interrupt lines, and checks the responses against a register model.
 */
`include "periph_settings.svh"

module tb_periph_subsystem;

  localparam int TIMEOUT = 40;
  localparam periph_pkg::addr_t dir_a    = `PERIPH_GPIO_BASE + {24'h0, `GPIO_DIR_OFS};
  localparam periph_pkg::addr_t out_a    = `PERIPH_GPIO_BASE + {24'h0, `GPIO_OUT_OFS};
  localparam periph_pkg::addr_t in_a     = `PERIPH_GPIO_BASE + {24'h0, `GPIO_IN_OFS};
  localparam periph_pkg::addr_t ien_a    = `PERIPH_GPIO_BASE + {24'h0, `GPIO_INTR_EN_OFS};
  localparam periph_pkg::addr_t stat_a   = `PERIPH_GPIO_BASE + {24'h0, `GPIO_INTR_STAT_OFS};
  localparam periph_pkg::addr_t enable_a = `PERIPH_IRQ_BASE + {24'h0, `IRQ_ENABLE_OFS};
  localparam periph_pkg::addr_t claim_a  = `PERIPH_IRQ_BASE + {24'h0, `IRQ_CLAIM_OFS};
  localparam periph_pkg::addr_t bad_a    = 32'h4000_0000;

  logic               clk = 1'b0;
  logic               reset;
  logic               req;
  periph_pkg::addr_t  addr;
  logic               we;
  periph_pkg::be_t    be;
  periph_pkg::data_t  wdata;
  periph_pkg::gpio_t  gpio;
  logic [1:0]         ext_intr;
  logic               gnt;
  logic               rvalid;
  periph_pkg::data_t  rdata;
  logic               err;
  periph_pkg::gpio_t  gpio_out;
  periph_pkg::gpio_t  gpio_oe;
  logic [7:0]         gpio_intr;
  logic               irq;

  // Register model, counters and the back-to-back request list
  periph_pkg::gpio_t  exp_oe;
  periph_pkg::gpio_t  exp_out;
  int                 seed;
  int                 errors;
  int                 test_base;
  int                 tests_run;
  int                 tests_failed;
  int                 accepted;
  periph_pkg::data_t  rsp_data[$];
  periph_pkg::addr_t  q_addr[$];
  logic               q_we[$];
  periph_pkg::data_t  q_wdata[$];
  periph_pkg::data_t  q_exp[$];

  periph_subsystem dut_i (
    .clk_i(clk), .reset_i(reset), .req_i(req), .addr_i(addr), .we_i(we), .be_i(be),
    .wdata_i(wdata), .gpio_i(gpio), .ext_intr_i(ext_intr), .gnt_o(gnt), .rvalid_o(rvalid),
    .rdata_o(rdata), .err_o(err), .gpio_o(gpio_out), .gpio_oe_o(gpio_oe),
    .gpio_intr_o(gpio_intr), .irq_o(irq)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (reset) begin
      accepted <= 0;
    end else if (req && gnt) begin
      accepted <= accepted + 1;
    end
  end

  // Every response in arrival order
  always @(negedge clk) begin
    if (!reset && rvalid) begin
      rsp_data.push_back(rdata);
    end
  end

  a_gnt: assert property (@(posedge clk) disable iff (reset) gnt == req)
    else report_mismatch("gnt_o", periph_pkg::data_t'(req), periph_pkg::data_t'(gnt));
  a_oe: assert property (@(posedge clk) disable iff (reset) gpio_oe == exp_oe)
    else report_mismatch("gpio_oe_o", periph_pkg::data_t'(exp_oe), periph_pkg::data_t'(gpio_oe));
  a_out: assert property (@(posedge clk) disable iff (reset) gpio_out == exp_out)
    else report_mismatch("gpio_o", periph_pkg::data_t'(exp_out), periph_pkg::data_t'(gpio_out));

  task automatic report_mismatch(input string name, input periph_pkg::data_t exp,
                                 input periph_pkg::data_t act);
    $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic check_value(input string name, input periph_pkg::data_t exp,
                             input periph_pkg::data_t act);
    assert (act == exp) else report_mismatch(name, exp, act);
  endtask

  task automatic timed_out(input string what);
    $display("Timeout waiting for %s", what);
    $display("Simulation failed");
    $finish;
  endtask

  // One bus transfer, returns at the falling edge where rvalid_o is high
  task automatic access_bus(input periph_pkg::addr_t a, input logic w, input periph_pkg::be_t b,
                            input periph_pkg::data_t d, output periph_pkg::data_t rd,
                            output logic er);
    int n;
    @(negedge clk);
    req = 1'b1;
    addr = a;
    we = w;
    be = b;
    wdata = d;
    @(negedge clk);
    req = 1'b0;
    n = 0;
    while (!rvalid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!rvalid) begin
      timed_out("rvalid_o");
    end else begin
      rd = rdata;
      er = err;
    end
  endtask

  task automatic write_reg(input periph_pkg::addr_t a, input periph_pkg::be_t b,
                           input periph_pkg::data_t d);
    periph_pkg::data_t rd;
    logic              er;
    access_bus(a, 1'b1, b, d, rd, er);
    check_value("err_o", '0, periph_pkg::data_t'(er));
  endtask

  task automatic read_check(input periph_pkg::addr_t a, input periph_pkg::data_t exp,
                            input logic exp_err);
    periph_pkg::data_t rd;
    logic              er;
    access_bus(a, 1'b0, 4'hf, '0, rd, er);
    check_value("rdata_o", exp, rd);
    check_value("err_o", periph_pkg::data_t'(exp_err), periph_pkg::data_t'(er));
  endtask

  // Byte lanes with their enable set take the new value
  function automatic periph_pkg::gpio_t merge_lanes(input periph_pkg::gpio_t cur,
      input periph_pkg::gpio_t val, input periph_pkg::be_t lanes);
    periph_pkg::gpio_t res;
    res = cur;
    for (int k = 0; k < 2; k++) begin
      if (lanes[k]) begin
        res[8*k +: 8] = val[8*k +: 8];
      end
    end
    return res;
  endfunction

  task automatic queue_access(input periph_pkg::addr_t a, input logic w,
                              input periph_pkg::data_t d, input periph_pkg::data_t exp);
    q_addr.push_back(a);
    q_we.push_back(w);
    q_wdata.push_back(d);
    q_exp.push_back(exp);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_base) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  initial begin
    periph_pkg::data_t rnd;
    periph_pkg::be_t   lanes;
    int                n;
    int                acc_base;
    int                rsp_base;
    seed = 32'hf1db_d87e;
    errors = 0;
    test_base = 0;
    tests_run = 0;
    tests_failed = 0;
    req = 1'b0;
    addr = '0;
    we = 1'b0;
    be = '0;
    wdata = '0;
    gpio = '0;
    ext_intr = '0;
    exp_oe = '0;
    exp_out = '0;
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      lanes = rnd[3:0];
      rnd = $random(seed);
      write_reg(dir_a, lanes, rnd);
      exp_oe = merge_lanes(exp_oe, rnd[15:0], lanes);
      rnd = $random(seed);
      write_reg(out_a, lanes, rnd);
      exp_out = merge_lanes(exp_out, rnd[15:0], lanes);
      read_check(dir_a, periph_pkg::data_t'(exp_oe), 1'b0);
      read_check(out_a, periph_pkg::data_t'(exp_out), 1'b0);
    end
    end_test("gpio outputs");

    gpio = periph_pkg::gpio_t'($random(seed));
    repeat (3) @(negedge clk);
    read_check(in_a, periph_pkg::data_t'(gpio), 1'b0);
    write_reg(in_a, 4'hf, ~periph_pkg::data_t'(gpio));
    read_check(in_a, periph_pkg::data_t'(gpio), 1'b0);
    read_check(bad_a, '0, 1'b1);
    read_check(`PERIPH_GPIO_BASE + `PERIPH_WIN_SIZE, '0, 1'b1);
    end_test("inputs and errors");

    gpio = '0;
    repeat (3) @(negedge clk);
    write_reg(stat_a, 4'h3, 32'h0000_ffff);
    write_reg(ien_a, 4'h3, 32'h0000_0008);
    gpio[3] = 1'b1;
    n = 0;
    while (!gpio_intr[3] && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!gpio_intr[3]) begin
      timed_out("gpio_intr_o bit 3");
    end
    read_check(stat_a, 32'h0000_0008, 1'b0);
    // Pin 5 is not enabled, so only its status bit moves
    gpio[5] = 1'b1;
    repeat (4) @(negedge clk);
    check_value("gpio_intr_o", 32'h0000_0008, periph_pkg::data_t'(gpio_intr));
    read_check(stat_a, 32'h0000_0028, 1'b0);
    write_reg(stat_a, 4'h3, 32'h0000_0028);
    check_value("gpio_intr_o", '0, periph_pkg::data_t'(gpio_intr));
    end_test("gpio interrupts");

    write_reg(ien_a, 4'h3, 32'h0000_0400);
    write_reg(enable_a, 4'h3, 32'h0000_0408);
    gpio[10] = 1'b1;
    n = 0;
    while (!irq && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!irq) begin
      timed_out("irq_o");
    end
    ext_intr = 2'b10;
    read_check(claim_a, 32'd3, 1'b0);
    write_reg(stat_a, 4'h3, 32'h0000_0400);
    write_reg(claim_a, 4'h1, 32'd3);
    read_check(claim_a, 32'd10, 1'b0);
    ext_intr = 2'b00;
    write_reg(claim_a, 4'h1, 32'd10);
    check_value("irq_o", '0, periph_pkg::data_t'(irq));
    read_check(claim_a, '0, 1'b0);
    end_test("interrupt controller");

    rnd = $random(seed);
    queue_access(ien_a, 1'b1, rnd, '0);
    queue_access(ien_a, 1'b0, '0, {16'h0, rnd[15:0]});
    rnd = $random(seed);
    queue_access(enable_a, 1'b1, rnd, '0);
    queue_access(enable_a, 1'b0, '0, {16'h0, rnd[15:1], 1'b0});
    queue_access(dir_a, 1'b0, '0, periph_pkg::data_t'(exp_oe));
    queue_access(out_a, 1'b0, '0, periph_pkg::data_t'(exp_out));
    queue_access(bad_a, 1'b0, '0, '0);
    queue_access(in_a, 1'b0, '0, periph_pkg::data_t'(gpio));
    @(posedge clk);
    acc_base = accepted;
    rsp_base = rsp_data.size();
    foreach (q_addr[k]) begin
      @(negedge clk);
      req = 1'b1;
      addr = q_addr[k];
      we = q_we[k];
      be = 4'hf;
      wdata = q_wdata[k];
    end
    @(negedge clk);
    req = 1'b0;
    n = 0;
    while (rsp_data.size() - rsp_base < q_addr.size() && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rsp_data.size() - rsp_base < q_addr.size()) begin
      timed_out("back-to-back responses");
    end
    repeat (3) @(posedge clk);
    check_value("accepted requests", q_addr.size(), periph_pkg::data_t'(accepted - acc_base));
    check_value("rvalid_o pulses", periph_pkg::data_t'(accepted - acc_base),
                periph_pkg::data_t'(rsp_data.size() - rsp_base));
    foreach (q_addr[k]) begin
      if (!q_we[k]) begin
        check_value("rdata_o", q_exp[k], rsp_data[rsp_base + k]);
      end
    end
    end_test("back-to-back");

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
periph_pkg.sv
periph_req_decode.sv
gpio_bank.sv
irq_ctrl.sv
periph_resp.sv
periph_subsystem.sv
tb_periph_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the peripheral subsystem testbench
VERILATOR  ?= verilator
TB_TOP     ?= tb_periph_subsystem
RTL_TOP    ?= periph_subsystem
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_MSG   ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

# The run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
